// ==== common/exu_pkg.sv ====
package exu_pkg;

  localparam int XLEN = 32;

  // RV32I major opcodes kept by this slice.
  typedef enum logic [6:0] {
    OP_R      = 7'b0110011,
    OP_I      = 7'b0010011,
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASSB
  } alu_op_e;

  // Encoded as funct3 so the decoder can take it directly.
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_cond_e;

  typedef enum logic [2:0] {
    SYS_NONE, SYS_CSRRW, SYS_CSRRS, SYS_CSRRC, SYS_ECALL, SYS_EBREAK, SYS_MRET
  } sys_op_e;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    br_cond_e        br_cond;
    sys_op_e         sys_op;
    opcode_e         opcode;
    logic [11:0]     csr_addr;
    logic [4:0]      rd;
    logic            rd_we;
    logic            illegal;
  } dec_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic            rd_we;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] npc;
    logic            ebreak;
  } result_t;

endpackage

// ==== decode/idu_decode.sv ====
`timescale 1ns/1ps

module idu_decode import exu_pkg::*; (
  input  logic [31:0]     instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  output dec_t            dec_o
);

  logic [6:0]      opc;
  logic [2:0]      funct3;
  logic            alt;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] zimm;

  assign opc    = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign alt    = instr_i[30];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  assign zimm  = {27'b0, instr_i[19:15]}; // rs1 field as unsigned immediate.

  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic f7_alt);
    case (f3)
      3'b000:  alu_sel = f7_alt ? SUB : ADD;
      3'b001:  alu_sel = SLL;
      3'b010:  alu_sel = SLT;
      3'b011:  alu_sel = SLTU;
      3'b100:  alu_sel = XOR;
      3'b101:  alu_sel = f7_alt ? SRA : SRL;
      3'b110:  alu_sel = OR;
      default: alu_sel = AND;
    endcase
  endfunction

  always_comb begin
    dec_o.pc       = pc_i;
    dec_o.src_a    = rs1_data_i;
    dec_o.src_b    = rs2_data_i;
    dec_o.imm      = imm_i;
    dec_o.alu_op   = ADD;
    dec_o.br_cond  = BEQ;
    dec_o.sys_op   = SYS_NONE;
    dec_o.opcode   = OP_I;
    dec_o.csr_addr = instr_i[31:20];
    dec_o.rd       = instr_i[11:7];
    dec_o.rd_we    = 1'b0;
    dec_o.illegal  = 1'b0;
    case (opc)
      OP_R: begin
        dec_o.opcode = OP_R;
        dec_o.alu_op = alu_sel(funct3, alt);
        dec_o.rd_we  = 1'b1;
      end
      OP_I: begin
        dec_o.src_b  = imm_i;
        dec_o.alu_op = alu_sel(funct3, alt & (funct3 == 3'b101)); // Bit 30 is imm except SRAI.
        dec_o.rd_we  = 1'b1;
      end
      OP_LUI: begin
        dec_o.opcode = OP_LUI;
        dec_o.imm    = imm_u;
        dec_o.src_b  = imm_u;
        dec_o.alu_op = PASSB;
        dec_o.rd_we  = 1'b1;
      end
      OP_AUIPC: begin
        dec_o.opcode = OP_AUIPC;
        dec_o.imm    = imm_u;
        dec_o.src_a  = pc_i;
        dec_o.src_b  = imm_u;
        dec_o.rd_we  = 1'b1;
      end
      OP_JAL: begin
        dec_o.opcode = OP_JAL;
        dec_o.imm    = imm_j;
        dec_o.rd_we  = 1'b1;
      end
      OP_JALR: begin
        dec_o.opcode = OP_JALR;
        dec_o.rd_we  = 1'b1;
      end
      OP_BRANCH: begin
        dec_o.opcode = OP_BRANCH;
        dec_o.imm    = imm_b;
        dec_o.alu_op = SUB;
        if (funct3[2:1] == 2'b01) dec_o.illegal = 1'b1;
        else dec_o.br_cond = br_cond_e'(funct3);
      end
      OP_SYSTEM: begin
        dec_o.opcode = OP_SYSTEM;
        if (funct3 == 3'b000) begin
          case (instr_i[31:20])
            12'h000: dec_o.sys_op = SYS_ECALL;
            12'h001: dec_o.sys_op = SYS_EBREAK;
            12'h302: dec_o.sys_op = SYS_MRET;
            default: dec_o.illegal = 1'b1;
          endcase
        end else if (funct3 == 3'b100) begin
          dec_o.illegal = 1'b1;
        end else begin
          case (funct3[1:0])
            2'b01:   dec_o.sys_op = SYS_CSRRW;
            2'b10:   dec_o.sys_op = SYS_CSRRS;
            default: dec_o.sys_op = SYS_CSRRC;
          endcase
          if (funct3[2]) dec_o.src_a = zimm;
          dec_o.rd_we = 1'b1;
        end
      end
      default: dec_o.illegal = 1'b1; // Loads, stores and the rest.
    endcase
    if (dec_o.illegal) begin
      dec_o.sys_op = SYS_NONE;
      dec_o.rd_we  = 1'b0;
    end
    if (dec_o.rd == 5'd0) dec_o.rd_we = 1'b0;
  end

endmodule

// ==== execute/exu_alu.sv ====
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  input  alu_op_e         op_i,
  output logic [XLEN-1:0] res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      ADD:     res_o = a_i + b_i;
      SUB:     res_o = a_i - b_i;
      SLL:     res_o = a_i << shamt;
      SLT:     res_o = {{(XLEN-1){1'b0}}, lt_s};
      SLTU:    res_o = {{(XLEN-1){1'b0}}, lt_u};
      XOR:     res_o = a_i ^ b_i;
      SRL:     res_o = a_i >> shamt;
      SRA:     res_o = $signed(a_i) >>> shamt;
      OR:      res_o = a_i | b_i;
      AND:     res_o = a_i & b_i;
      PASSB:   res_o = b_i; // LUI.
      default: res_o = '0;
    endcase
  end

endmodule

// ==== execute/exu_csr.sv ====
`timescale 1ns/1ps

module exu_csr import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [11:0]     raddr_i,
  output logic [XLEN-1:0] rdata_o,
  input  logic            we_i,
  input  logic [11:0]     waddr_i,
  input  logic [XLEN-1:0] wdata_i,
  input  logic            trap_enter_i,
  input  logic [XLEN-1:0] trap_pc_i,
  input  logic            trap_return_i,
  output logic [XLEN-1:0] mtvec_o,
  output logic [XLEN-1:0] mepc_o
);

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (we_i) begin
        case (waddr_i)
          CSR_MSTATUS: mstatus <= wdata_i;
          CSR_MTVEC:   mtvec   <= wdata_i;
          CSR_MEPC:    mepc    <= wdata_i;
          CSR_MCAUSE:  mcause  <= wdata_i;
          default: ;
        endcase
      end
      if (trap_enter_i) begin
        mepc   <= trap_pc_i;
        mcause <= CAUSE_ECALL_M;
      end
      if (trap_return_i) begin
        mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
        mstatus[MSTATUS_MPIE] <= 1'b1;
      end
    end
  end

  always_comb begin
    case (raddr_i)
      CSR_MSTATUS: rdata_o = mstatus;
      CSR_MTVEC:   rdata_o = mtvec;
      CSR_MEPC:    rdata_o = mepc;
      CSR_MCAUSE:  rdata_o = mcause;
      default:     rdata_o = '0; // Unimplemented CSRs read as zero.
    endcase
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

  // Only one instruction retires per cycle, so ECALL and MRET cannot coincide.
  a_one_trap: assert property (@(posedge clk) disable iff (rst)
    !(trap_enter_i && trap_return_i))
    else $error("trap entry and return in the same cycle");

endmodule

// ==== execute/exu_stage.sv ====
`timescale 1ns/1ps

module exu_stage import exu_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  dec_t    dec_i,
  output logic    res_valid_o,
  input  logic    res_ready_i,
  output result_t res_o
);

  dec_t            q;
  logic            full;
  logic            load;
  logic            leave;
  logic            taken;
  logic            is_csr;
  logic            csr_wr;
  logic            csr_we;
  logic [11:0]     csr_waddr;
  logic [XLEN-1:0] csr_wdata;
  logic            trap_enter;
  logic            trap_return;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] csr_rdata;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] br_target;
  logic [XLEN-1:0] jalr_sum;

  assign leave       = full & res_ready_i;
  assign in_ready_o  = ~full | res_ready_i;
  assign load        = in_valid_i & in_ready_o;
  assign res_valid_o = full;

  always_ff @(posedge clk) begin
    if (rst) full <= 1'b0;
    else if (load) full <= 1'b1;
    else if (leave) full <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (load) q <= dec_i;
  end

  exu_alu u_alu (.a_i(q.src_a), .b_i(q.src_b), .op_i(q.alu_op), .res_o(alu_res));

  always_comb begin
    case (q.br_cond)
      BEQ:     taken = q.src_a == q.src_b;
      BNE:     taken = q.src_a != q.src_b;
      BLT:     taken = $signed(q.src_a) < $signed(q.src_b);
      BGE:     taken = $signed(q.src_a) >= $signed(q.src_b);
      BLTU:    taken = q.src_a < q.src_b;
      BGEU:    taken = q.src_a >= q.src_b;
      default: taken = 1'b0;
    endcase
  end

  assign is_csr = ~q.illegal & (q.opcode == OP_SYSTEM) &
                  (q.sys_op inside {SYS_CSRRW, SYS_CSRRS, SYS_CSRRC});

  always_comb begin
    case (q.sys_op)
      SYS_CSRRS: csr_wdata = csr_rdata | q.src_a;
      SYS_CSRRC: csr_wdata = csr_rdata & ~q.src_a;
      default:   csr_wdata = q.src_a;
    endcase
  end

  // Set and clear with a zero operand only read.
  assign csr_wr      = is_csr & ((q.sys_op == SYS_CSRRW) | (q.src_a != '0));
  assign csr_we      = leave & csr_wr;
  assign csr_waddr   = q.csr_addr;
  assign trap_enter  = leave & ~q.illegal & (q.sys_op == SYS_ECALL);
  assign trap_return = leave & ~q.illegal & (q.sys_op == SYS_MRET);

  exu_csr u_csr (
    .clk(clk), .rst(rst),
    .raddr_i(q.csr_addr), .rdata_o(csr_rdata),
    .we_i(csr_we), .waddr_i(csr_waddr), .wdata_i(csr_wdata),
    .trap_enter_i(trap_enter), .trap_pc_i(q.pc), .trap_return_i(trap_return),
    .mtvec_o(mtvec), .mepc_o(mepc)
  );

  assign pc_plus4  = q.pc + 32'd4;
  assign br_target = q.pc + q.imm;
  assign jalr_sum  = q.src_a + q.imm;

  always_comb begin
    res_o.rd     = q.rd;
    res_o.rd_we  = q.rd_we;
    res_o.wdata  = alu_res;
    res_o.npc    = pc_plus4;
    res_o.ebreak = 1'b0;
    if (!q.illegal) begin
      case (q.opcode)
        OP_JAL: begin
          res_o.wdata = pc_plus4;
          res_o.npc   = br_target;
        end
        OP_JALR: begin
          res_o.wdata = pc_plus4;
          res_o.npc   = {jalr_sum[XLEN-1:1], 1'b0};
        end
        OP_BRANCH: if (taken) res_o.npc = br_target;
        OP_SYSTEM: begin
          res_o.wdata = csr_rdata; // Old value.
          case (q.sys_op)
            SYS_ECALL:  res_o.npc = mtvec;
            SYS_MRET:   res_o.npc = mepc;
            SYS_EBREAK: res_o.ebreak = 1'b1;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  a_hold: assert property (@(posedge clk) disable iff (rst)
    full && !res_ready_i |=> full && $stable(q))
    else $error("execute stage dropped or changed a stalled item");

  a_alu_op: assert property (@(posedge clk) disable iff (rst)
    full |-> q.alu_op inside {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASSB})
    else $error("ALU opcode out of range");

endmodule

// ==== hdl/wbu_result.sv ====
`timescale 1ns/1ps

module wbu_result import exu_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  result_t res_i,
  output logic    out_valid_o,
  input  logic    out_ready_i,
  output result_t res_o
);

  logic    valid;
  logic    load;
  result_t res_q;

  // Drain and refill in one cycle.
  assign in_ready_o = ~valid | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (out_ready_i) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) res_q <= res_i;
  end

  assign out_valid_o = valid;
  assign res_o       = res_q;

endmodule

// ==== hdl/exu_top.sv ====
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  logic [31:0]     instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output result_t         res_o
);

  dec_t    dec;
  result_t exu_res;
  logic    exu_valid;
  logic    wbu_ready;

  idu_decode u_decode (
    .instr_i(instr_i), .pc_i(pc_i),
    .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
    .dec_o(dec)
  );

  exu_stage u_stage (
    .clk(clk), .rst(rst),
    .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .dec_i(dec),
    .res_valid_o(exu_valid), .res_ready_i(wbu_ready), .res_o(exu_res)
  );

  wbu_result u_result (
    .clk(clk), .rst(rst),
    .in_valid_i(exu_valid), .in_ready_o(wbu_ready), .res_i(exu_res),
    .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .res_o(res_o)
  );

endmodule

// ==== sim/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker import exu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid_i,
  input  logic        in_ready_i,
  input  logic [31:0] instr_i,
  input  logic [31:0] pc_i,
  input  logic [31:0] rs1_i,
  input  logic [31:0] rs2_i,
  input  logic        out_valid_i,
  input  logic        out_ready_i,
  input  result_t     res_i,
  output int          checked_o,
  output int          errors_o
);

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
  } stim_t;

  stim_t       inq[$];
  logic [31:0] mstatus;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] mcause;
  logic        seen_in;
  logic        stalled;
  result_t     last_res;

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: alu_ref = alt ? a - b : a + b;
      3'd1: alu_ref = a << b[4:0];
      3'd2: alu_ref = {31'd0, $signed(a) < $signed(b)};
      3'd3: alu_ref = {31'd0, a < b};
      3'd4: alu_ref = a ^ b;
      3'd5: begin
        if (alt) alu_ref = $signed(a) >>> b[4:0];
        else alu_ref = a >> b[4:0];
      end
      3'd6:    alu_ref = a | b;
      default: alu_ref = a & b;
    endcase
  endfunction

  function automatic logic taken_ref(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
      3'd0:    taken_ref = a == b;
      3'd1:    taken_ref = a != b;
      3'd4:    taken_ref = $signed(a) < $signed(b);
      3'd5:    taken_ref = $signed(a) >= $signed(b);
      3'd6:    taken_ref = a < b;
      default: taken_ref = a >= b;
    endcase
  endfunction

  function automatic logic [31:0] csr_read(input logic [11:0] addr);
    case (addr)
      CSR_MSTATUS: csr_read = mstatus;
      CSR_MTVEC:   csr_read = mtvec;
      CSR_MEPC:    csr_read = mepc;
      CSR_MCAUSE:  csr_read = mcause;
      default:     csr_read = 32'd0;
    endcase
  endfunction

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] val);
    case (addr)
      CSR_MSTATUS: mstatus = val;
      CSR_MTVEC:   mtvec   = val;
      CSR_MEPC:    mepc    = val;
      CSR_MCAUSE:  mcause  = val;
      default: ;
    endcase
  endtask

  // Expected result of one instruction, advancing the CSR model.
  task automatic model(input stim_t s, output result_t e);
    logic [2:0]  f3;
    logic [11:0] csr;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] op;
    logic [31:0] old;
    f3    = s.instr[14:12];
    csr   = s.instr[31:20];
    imm_i = {{20{s.instr[31]}}, s.instr[31:20]};
    imm_b = {{20{s.instr[31]}}, s.instr[7], s.instr[30:25], s.instr[11:8], 1'b0};
    imm_u = {s.instr[31:12], 12'd0};
    imm_j = {{12{s.instr[31]}}, s.instr[19:12], s.instr[20], s.instr[30:21], 1'b0};
    e.rd     = s.instr[11:7];
    e.rd_we  = 1'b1;
    e.wdata  = 32'd0;
    e.npc    = s.pc + 32'd4;
    e.ebreak = 1'b0;
    case (s.instr[6:0])
      7'h33: e.wdata = alu_ref(f3, s.instr[30], s.a, s.b);
      7'h13: e.wdata = alu_ref(f3, s.instr[30] && f3 == 3'd5, s.a, imm_i);
      7'h37: e.wdata = imm_u;
      7'h17: e.wdata = s.pc + imm_u;
      7'h6f: begin
        e.wdata = s.pc + 32'd4;
        e.npc   = s.pc + imm_j;
      end
      7'h67: begin
        e.wdata = s.pc + 32'd4;
        e.npc   = (s.a + imm_i) & ~32'd1;
      end
      7'h63: begin
        e.rd_we = 1'b0;
        if (taken_ref(f3, s.a, s.b)) e.npc = s.pc + imm_b;
      end
      default: begin
        if (f3 == 3'd0) begin
          e.rd_we = 1'b0;
          if (csr == 12'h000) begin
            e.npc  = mtvec;
            mepc   = s.pc;
            mcause = 32'd11;
          end else if (csr == 12'h302) begin
            e.npc      = mepc;
            mstatus[3] = mstatus[7];
            mstatus[7] = 1'b1;
          end else begin
            e.ebreak = 1'b1;
          end
        end else begin
          op      = f3[2] ? {27'd0, s.instr[19:15]} : s.a;
          old     = csr_read(csr);
          e.wdata = old;
          if (f3[1:0] == 2'b01) csr_write(csr, op);
          else if (op != 32'd0) csr_write(csr, (f3[1:0] == 2'b10) ? (old | op) : (old & ~op));
        end
      end
    endcase
    if (e.rd == 5'd0) e.rd_we = 1'b0;
  endtask

  function automatic int field_mismatch(input string name, input logic [31:0] exp,
                                        input logic [31:0] act);
    field_mismatch = 0;
    if (exp !== act) begin
      $display("mismatch at %0t: %s expected 0x%h, got 0x%h", $time, name, exp, act);
      field_mismatch = 1;
    end
  endfunction

  always @(posedge clk) begin
    stim_t   s;
    result_t e;
    int      bad;
    logic    exp_ready;
    if (rst) begin
      inq.delete();
      mstatus   = '0;
      mtvec     = '0;
      mepc      = '0;
      mcause    = '0;
      seen_in   = 1'b0;
      stalled   = 1'b0;
      checked_o <= 0;
      errors_o  <= 0;
    end else begin
      bad = 0;
      exp_ready = (inq.size() < 2) || out_ready_i; // Two in flight fill both stages.
      bad += field_mismatch("in_ready_o", 32'(exp_ready), 32'(in_ready_i));
      if (out_valid_i && !seen_in) begin
        $display("out_valid_o went high before any instruction was accepted");
        bad++;
      end
      if (stalled && !out_valid_i) begin
        $display("out_valid_o dropped while the output was stalled at %0t", $time);
        bad++;
      end
      if (stalled && res_i !== last_res) begin
        $display("res_o changed while the output was stalled at %0t", $time);
        bad++;
      end
      if (out_valid_i && out_ready_i) begin
        if (inq.size() == 0) begin
          $display("a result came out with no instruction left to match it");
          bad++;
        end else begin
          s = inq.pop_front();
          model(s, e);
          bad += field_mismatch("res_o.rd", 32'(e.rd), 32'(res_i.rd));
          bad += field_mismatch("res_o.rd_we", 32'(e.rd_we), 32'(res_i.rd_we));
          if (e.rd_we) bad += field_mismatch("res_o.wdata", e.wdata, res_i.wdata);
          bad += field_mismatch("res_o.npc", e.npc, res_i.npc);
          bad += field_mismatch("res_o.ebreak", 32'(e.ebreak), 32'(res_i.ebreak));
          checked_o <= checked_o + 1;
        end
      end
      if (in_valid_i && in_ready_i) begin
        inq.push_back({instr_i, pc_i, rs1_i, rs2_i});
        seen_in = 1'b1;
      end
      stalled  = out_valid_i && !out_ready_i;
      last_res = res_i;
      errors_o <= errors_o + bad;
    end
  end

endmodule

// ==== sim/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import exu_pkg::*; ();

  logic        clk;
  logic        rst;
  logic        in_valid_i;
  logic        in_ready_o;
  logic [31:0] instr_i;
  logic [31:0] pc_i;
  logic [31:0] rs1_data_i;
  logic [31:0] rs2_data_i;
  logic        out_valid_o;
  logic        out_ready_i;
  result_t     res_o;
  int          checked;
  int          errors;
  logic        ok;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  exu_top dut (
    .clk(clk), .rst(rst),
    .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
    .instr_i(instr_i), .pc_i(pc_i),
    .rs1_data_i(rs1_data_i), .rs2_data_i(rs2_data_i),
    .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .res_o(res_o)
  );

  tb_checker u_checker (
    .clk(clk), .rst(rst),
    .in_valid_i(in_valid_i), .in_ready_i(in_ready_o),
    .instr_i(instr_i), .pc_i(pc_i), .rs1_i(rs1_data_i), .rs2_i(rs2_data_i),
    .out_valid_i(out_valid_o), .out_ready_i(out_ready_i), .res_i(res_o),
    .checked_o(checked), .errors_o(errors)
  );

  function automatic logic [11:0] pick_csr();
    case ($urandom % 5)
      0:       pick_csr = CSR_MSTATUS;
      1:       pick_csr = CSR_MTVEC;
      2:       pick_csr = CSR_MEPC;
      3:       pick_csr = CSR_MCAUSE;
      default: pick_csr = 12'h340; // Not implemented, reads zero.
    endcase
  endfunction

  // Kinds: 0 R, 1 I, 2 LUI, 3 AUIPC, 4 JAL, 5 JALR, 6 branch, 7 CSR, 8 ECALL, 9 MRET, 10 EBREAK.
  function automatic logic [31:0] make_instr(input int kind, input logic zero_rs1);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [6:0]  f7;
    rd  = 5'($urandom);
    rs1 = zero_rs1 ? 5'd0 : 5'($urandom);
    rs2 = 5'($urandom);
    f3  = 3'($urandom);
    imm = 12'($urandom);
    f7  = (($urandom % 2 != 0) && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
    case (kind)
      0: make_instr = {f7, rs2, rs1, f3, rd, 7'h33};
      1: begin
        if (f3 == 3'b001 || f3 == 3'b101) imm[11:5] = f7; // Shifts.
        make_instr = {imm, rs1, f3, rd, 7'h13};
      end
      2: make_instr = {imm, rs1, f3, rd, 7'h37};
      3: make_instr = {imm, rs1, f3, rd, 7'h17};
      4: make_instr = {imm, rs1, f3, rd, 7'h6f};
      5: make_instr = {imm, rs1, 3'b000, rd, 7'h67};
      6: begin
        if (f3[2:1] == 2'b01) f3[2] = 1'b1;
        make_instr = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h63};
      end
      7: begin
        if (f3[1:0] == 2'b00) f3[1:0] = 2'b01;
        make_instr = {pick_csr(), rs1, f3, rd, 7'h73};
      end
      8:       make_instr = 32'h0000_0073;
      9:       make_instr = 32'h3020_0073;
      default: make_instr = 32'h0010_0073;
    endcase
  endfunction

  task automatic drive_next(input int lo, input int hi);
    int          kind;
    logic        zero;
    logic [31:0] a;
    kind = lo + int'($urandom % (hi - lo + 1));
    zero = (kind == 7) && ($urandom % 4 == 0);
    a    = zero ? 32'd0 : $urandom;
    instr_i    <= make_instr(kind, zero);
    pc_i       <= $urandom & 32'hffff_fffc;
    rs1_data_i <= a;
    rs2_data_i <= ($urandom % 4 == 0) ? a : $urandom; // Equal operands now and then.
    in_valid_i <= 1'b1;
  endtask

  task automatic run_test(input string name, input int lo, input int hi, input int n,
                          input int pct);
    int   sent;
    int   idle;
    int   base_chk;
    int   base_err;
    logic accepted;
    sent     = 0;
    idle     = 0;
    base_chk = checked;
    base_err = errors;
    while (ok && sent < n) begin
      @(posedge clk);
      accepted = in_valid_i && in_ready_o;
      if (accepted) begin
        sent++;
        idle = 0;
      end else begin
        idle++;
      end
      if (!in_valid_i || accepted) begin
        if (sent < n && $urandom % 4 != 0) drive_next(lo, hi);
        else in_valid_i <= 1'b0;
      end
      out_ready_i <= ($urandom % 100) < pct;
      if (idle >= 1000) begin
        $display("timeout: test %s stopped accepting instructions", name);
        ok = 1'b0;
      end
    end
    idle = 0;
    while (ok && checked - base_chk < n) begin
      @(posedge clk);
      out_ready_i <= ($urandom % 100) < pct;
      idle++;
      if (idle >= 1000) begin
        $display("timeout: test %s is missing results", name);
        ok = 1'b0;
      end
    end
    if (ok) $display("test %s: %0d results, %0d errors", name, checked - base_chk,
                     errors - base_err);
  endtask

  initial begin
    ok = 1'b1;
    void'($urandom(32'h277b_75fb));
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    instr_i     = '0;
    pc_i        = '0;
    rs1_data_i  = '0;
    rs2_data_i  = '0;
    out_ready_i = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    run_test("integer ops", 0, 3, 200, 80);
    run_test("control flow", 4, 6, 200, 80);
    run_test("csr access", 7, 7, 200, 80);
    run_test("trap entry and return", 7, 10, 200, 80);
    run_test("back-pressure", 0, 10, 400, 30);
    $display("%0d results checked, %0d errors", checked, errors);
    if (ok && errors == 0) $display("*** PASSED ***");
    else $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== list.f ====
common/exu_pkg.sv
decode/idu_decode.sv
execute/exu_alu.sv
execute/exu_csr.sv
execute/exu_stage.sv
hdl/wbu_result.sv
hdl/exu_top.sv
sim/tb_checker.sv
sim/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f list.f --top-module tb_top -o tb_sim

# The simulation output goes to the terminal; the status comes from the search.
./obj_dir/tb_sim | tee /dev/stderr | grep -q -F '*** PASSED ***'
